//--- source/gem_link_pkg.sv
package gem_link_pkg;

   //--------------------------------------------------------------------------
   // Link geometry
   //--------------------------------------------------------------------------

   localparam int NUM_LINKS         = 4;     // Optical trigger links
   localparam int CLUSTER_BITS      = 112;   // Full cluster word from the chamber
   localparam int LINK_PAYLOAD_BITS = 56;    // Even links low half, odd links high half
   localparam int WORD_BITS         = 16;    // Transceiver word
   localparam int FRAMES_PER_BX     = 4;     // Words per bunch crossing at 160 MHz line rate

   //--------------------------------------------------------------------------
   // 8b10b control characters
   //--------------------------------------------------------------------------

   localparam logic [7:0] K_BC0      = 8'hBC; // K.28.5 bunch crossing zero
   localparam logic [7:0] K_RESYNC   = 8'h3C; // K.28.1
   localparam logic [7:0] K_OVERFLOW = 8'hFE; // K.30.7 more than 8 clusters

   // Bunch sequence markers, cycled by the two BX counter LSBs
   localparam logic [7:0] K_SEQ0 = 8'h1C;     // K.28.0
   localparam logic [7:0] K_SEQ1 = 8'hF7;     // K.23.7
   localparam logic [7:0] K_SEQ2 = 8'hFB;     // K.27.7
   localparam logic [7:0] K_SEQ3 = 8'hFD;     // K.29.7

   localparam logic [WORD_BITS-1:0] IDLE_WORD = 16'hFFFC; // Comma in low byte

   //--------------------------------------------------------------------------
   // Startup milestones in units of STARTUP_UNIT cycles
   //--------------------------------------------------------------------------

   // Element i is the release point of link i
   localparam logic [NUM_LINKS-1:0][7:0] MGT_RELEASE_UNITS = {8'd14, 8'd12, 8'd8, 8'd4};
   localparam int TXRESET_UNIT = 18;          // One cycle PCS reset
   localparam int DONE_UNIT    = 30;          // Startup done strictly after this

   //--------------------------------------------------------------------------
   // Types
   //--------------------------------------------------------------------------

   typedef logic [LINK_PAYLOAD_BITS-1:0] link_payload_t;

   typedef struct packed {
      logic       bc0;       // Bunch crossing zero
      logic       resync;    // TTC resync
      logic [1:0] bxn_lsbs;  // Low bits of the BX counter
      logic       overflow;  // Cluster overflow on this crossing
   } bx_info_t;

   typedef struct packed {
      logic [WORD_BITS-1:0] data;
      logic [1:0]           isk;   // Bit 0 marks the low byte as a K-char
   } tx_word_t;

endpackage

//--- source/startup_sequencer.sv
module startup_sequencer #(
   parameter int STARTUP_UNIT = 40000  // Cycles per startup unit
) (
   input  logic                             clock_40,
   input  logic                             rst_n_i,
   input  logic [gem_link_pkg::NUM_LINKS-1:0] mgt_reset_i,  // Manual per-link reset
   input  logic                             txreset_i,      // Manual PCS reset
   output logic [gem_link_pkg::NUM_LINKS-1:0] mgt_reset_o,
   output logic                             tx_reset_o,
   output logic                             startup_done_o
);

   import gem_link_pkg::*;

   //--------------------------------------------------------------------------
   // Milestones scaled to clock_40 cycles
   //--------------------------------------------------------------------------

   localparam int TXRESET_CNT = TXRESET_UNIT * STARTUP_UNIT;
   localparam int DONE_CNT    = DONE_UNIT * STARTUP_UNIT;
   localparam int CNT_MAX     = DONE_CNT + 1;         // Saturate just past done
   localparam int CNT_BITS    = $clog2(CNT_MAX + 1);

   localparam logic [CNT_BITS-1:0] CNT_TOP = CNT_BITS'(CNT_MAX);

   logic [CNT_BITS-1:0] start_cnt;

   // Free running until saturation, restarted only by reset
   always_ff @(posedge clock_40) begin
      if (!rst_n_i) begin
         start_cnt <= '0;
      end else if (start_cnt < CNT_TOP) begin
         start_cnt <= start_cnt + 1'b1;
      end
   end

   //--------------------------------------------------------------------------
   // Staged transceiver reset release
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < NUM_LINKS; i++) begin : g_mgt_reset
      // Release point of this link
      localparam int RELEASE_CNT = int'(MGT_RELEASE_UNITS[i]) * STARTUP_UNIT;

      assign mgt_reset_o[i] = mgt_reset_i[i] | (start_cnt < CNT_BITS'(RELEASE_CNT));
   end

   // Single cycle pulse as the counter passes the milestone
   assign tx_reset_o = txreset_i | (start_cnt == CNT_BITS'(TXRESET_CNT));

   assign startup_done_o = (start_cnt > CNT_BITS'(DONE_CNT)); // Holds once saturated

endmodule

//--- source/link_ready_timer.sv
module link_ready_timer #(
   parameter int READY_HOLD = 262143  // Cycles of continuous activity before ready
) (
   input  logic clock_40,
   input  logic rst_n_i,
   input  logic link_active_i,
   output logic ready_o
);

   localparam int CNT_BITS = $clog2(READY_HOLD + 1);

   localparam logic [CNT_BITS-1:0] HOLD_MAX = CNT_BITS'(READY_HOLD);

   logic [CNT_BITS-1:0] hold_cnt;

   //--------------------------------------------------------------------------
   // Hold-off counter
   //--------------------------------------------------------------------------

   // Any drop of the link restarts the full hold
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !link_active_i) begin
         hold_cnt <= '0;
      end else if (hold_cnt < HOLD_MAX) begin
         hold_cnt <= hold_cnt + 1'b1;  // Saturates at the hold value
      end
   end

   assign ready_o = (hold_cnt == HOLD_MAX);

endmodule

//--- source/frame_sep_select.sv
module frame_sep_select (
   input  gem_link_pkg::bx_info_t bx_info_i,
   output logic [7:0]             sep_code_o   // Separator K-code for word 0
);

   import gem_link_pkg::*;

   //--------------------------------------------------------------------------
   // Separator priority
   //--------------------------------------------------------------------------

   // TTC characters take precedence over the overflow marker,
   // and the sequence markers fill every plain crossing
   always_comb begin
      if (bx_info_i.bc0) begin
         sep_code_o = K_BC0;
      end else if (bx_info_i.resync) begin
         sep_code_o = K_RESYNC;
      end else if (bx_info_i.overflow) begin
         sep_code_o = K_OVERFLOW;
      end else begin
         unique case (bx_info_i.bxn_lsbs)
            2'd0:    sep_code_o = K_SEQ0;
            2'd1:    sep_code_o = K_SEQ1;
            2'd2:    sep_code_o = K_SEQ2;
            default: sep_code_o = K_SEQ3;  // BX LSBs of 3
         endcase
      end
   end

endmodule

//--- source/link_framer.sv
module link_framer (
   input  logic                        clock_40,
   input  logic                        rst_n_i,
   input  logic                        link_active_i,
   input  logic                        bx_strobe_i,  // New bunch crossing
   input  gem_link_pkg::link_payload_t payload_i,
   input  logic [7:0]                  sep_code_i,
   output gem_link_pkg::tx_word_t      tx_word_o
);

   import gem_link_pkg::*;

   localparam int FRAME_BITS = $clog2(FRAMES_PER_BX);

   localparam logic [FRAME_BITS-1:0] LAST_FRAME = FRAME_BITS'(FRAMES_PER_BX - 1);

   link_payload_t         payload_q;   // Captured crossing
   logic [7:0]            sep_q;       // Its separator
   logic [FRAME_BITS-1:0] frame_cnt;   // Word being sent
   logic                  busy;        // Frame in progress

   //--------------------------------------------------------------------------
   // Capture on the strobe
   //--------------------------------------------------------------------------

   always_ff @(posedge clock_40) begin
      if (bx_strobe_i && link_active_i) begin
         payload_q <= payload_i;
         sep_q     <= sep_code_i;
      end
   end

   // Frame sequencing, an early strobe restarts at word 0
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !link_active_i) begin
         busy      <= 1'b0;
         frame_cnt <= '0;
      end else if (bx_strobe_i) begin
         busy      <= 1'b1;
         frame_cnt <= '0;
      end else if (busy) begin
         if (frame_cnt == LAST_FRAME) begin
            busy      <= 1'b0;  // Last word goes out this cycle
            frame_cnt <= '0;
         end else begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

   //--------------------------------------------------------------------------
   // Word mux
   //--------------------------------------------------------------------------

   always_comb begin
      tx_word_o = '{data: IDLE_WORD, isk: 2'b01};  // Idle comma
      if (link_active_i && busy) begin
         unique case (frame_cnt)
            2'd0: tx_word_o = '{data: {payload_q[7:0], sep_q}, isk: 2'b01};
            2'd1: tx_word_o = '{data: payload_q[23:8], isk: 2'b00};
            2'd2: tx_word_o = '{data: payload_q[39:24], isk: 2'b00};
            default: tx_word_o = '{data: payload_q[55:40], isk: 2'b00};
         endcase
      end
   end

endmodule

//--- source/gem_data_out.sv
module gem_data_out #(
   parameter int STARTUP_UNIT = 40000,   // About 1 ms at 40 MHz
   parameter int READY_HOLD   = 262143   // About 6.5 ms of stable link
) (
   input  logic                                     clock_40,
   input  logic                                     rst_n_i,
   input  logic                                     bx_strobe_i,
   input  logic [gem_link_pkg::CLUSTER_BITS-1:0]    cluster_data_i,
   input  gem_link_pkg::bx_info_t                   bx_info_i,
   input  logic [gem_link_pkg::NUM_LINKS-1:0]       tx_ready_i,      // Transceiver reset done
   input  logic                                     force_not_ready_i,
   input  logic [gem_link_pkg::NUM_LINKS-1:0]       mgt_reset_i,
   input  logic                                     txreset_i,
   output gem_link_pkg::tx_word_t [gem_link_pkg::NUM_LINKS-1:0] tx_words_o,
   output logic [gem_link_pkg::NUM_LINKS-1:0]       mgt_reset_o,
   output logic                                     tx_reset_o,
   output logic                                     ready_o
);

   import gem_link_pkg::*;

   logic       startup_done;
   logic       link_active;   // Shared by timer, selector and framers
   logic [7:0] sep_code;

   //--------------------------------------------------------------------------
   // Startup and link state
   //--------------------------------------------------------------------------

   startup_sequencer #(
      .STARTUP_UNIT (STARTUP_UNIT)
   ) u_startup (
      .clock_40       (clock_40),
      .rst_n_i        (rst_n_i),
      .mgt_reset_i    (mgt_reset_i),
      .txreset_i      (txreset_i),
      .mgt_reset_o    (mgt_reset_o),
      .tx_reset_o     (tx_reset_o),
      .startup_done_o (startup_done)
   );

   assign link_active = startup_done && (&tx_ready_i) && !force_not_ready_i;

   link_ready_timer #(
      .READY_HOLD (READY_HOLD)
   ) u_ready (
      .clock_40      (clock_40),
      .rst_n_i       (rst_n_i),
      .link_active_i (link_active),
      .ready_o       (ready_o)
   );

   // One separator for all links
   frame_sep_select u_sep (
      .bx_info_i  (bx_info_i),
      .sep_code_o (sep_code)
   );

   //--------------------------------------------------------------------------
   // Per-link framers
   //--------------------------------------------------------------------------

   for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
      link_framer u_framer (
         .clock_40      (clock_40),
         .rst_n_i       (rst_n_i),
         .link_active_i (link_active),
         .bx_strobe_i   (bx_strobe_i),
         .payload_i     (cluster_data_i[(i % 2) * LINK_PAYLOAD_BITS +: LINK_PAYLOAD_BITS]),
         .sep_code_i    (sep_code),
         .tx_word_o     (tx_words_o[i])
      );
   end

endmodule

//--- tb/tb_gem_data_out.sv
module tb_gem_data_out;

   timeunit 1ns;
   timeprecision 100ps;

   import gem_link_pkg::*;

   localparam int STARTUP_UNIT = 4;             // Short startup for simulation
   localparam int READY_HOLD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int WAIT_LIMIT   = 400;           // Cycles before a wait gives up
   localparam logic [31:0] SEED = 32'he2e340b4;

   // Link release points and milestones, in cycles after the counter starts
   localparam int RELEASE_UNIT [4] = '{4, 8, 12, 14};
   localparam int TXRESET_CYC = 18 * STARTUP_UNIT;
   localparam int DONE_CYC    = 30 * STARTUP_UNIT + 1;  // First count past the milestone

   localparam logic [7:0] SEQ_CODE [4] = '{8'h1C, 8'hF7, 8'hFB, 8'hFD};

   logic                     clock_40 = 1'b0;
   logic                     rst_n_i;
   logic                     bx_strobe_i;
   logic [CLUSTER_BITS-1:0]  cluster_data_i;
   bx_info_t                 bx_info_i;
   logic [NUM_LINKS-1:0]     tx_ready_i;
   logic                     force_not_ready_i;
   logic [NUM_LINKS-1:0]     mgt_reset_i;
   logic                     txreset_i;
   tx_word_t [NUM_LINKS-1:0] tx_words_o;
   logic [NUM_LINKS-1:0]     mgt_reset_o;
   logic                     tx_reset_o;
   logic                     ready_o;

   int cyc;       // Rising edges since reset release
   int checks;
   int errors;
   int timeouts;

   always #2 clock_40 = ~clock_40;  // 4 ns period

   gem_data_out #(
      .STARTUP_UNIT (STARTUP_UNIT),
      .READY_HOLD   (READY_HOLD)
   ) UUT (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .bx_strobe_i       (bx_strobe_i),
      .cluster_data_i    (cluster_data_i),
      .bx_info_i         (bx_info_i),
      .tx_ready_i        (tx_ready_i),
      .force_not_ready_i (force_not_ready_i),
      .mgt_reset_i       (mgt_reset_i),
      .txreset_i         (txreset_i),
      .tx_words_o        (tx_words_o),
      .mgt_reset_o       (mgt_reset_o),
      .tx_reset_o        (tx_reset_o),
      .ready_o           (ready_o)
   );

   //--------------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------------

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                  $time, name, actual, expected);
      end
   endtask

   task automatic check_word(input int link, input logic [15:0] data_exp,
                             input logic [1:0] isk_exp);
      check_value($sformatf("tx_words_o[%0d].data", link),
                  64'(tx_words_o[link].data), 64'(data_exp));
      check_value($sformatf("tx_words_o[%0d].isk", link),
                  64'(tx_words_o[link].isk), 64'(isk_exp));
   endtask

   task automatic check_all_idle();
      for (int i = 0; i < NUM_LINKS; i++) begin
         check_word(i, 16'hFFFC, 2'b01);  // Comma word
      end
   endtask

   // Checks read settled values first, drives follow in the same step
   task automatic next_cycle();
      @(posedge clock_40);
      #1;
      cyc++;
   endtask

   task automatic wait_for_ready(input string what);
      int n;
      n = 0;
      while (!ready_o && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!ready_o) begin
         timeouts++;
         $display("Timeout: ready_o never rose %s", what);
      end
   endtask

   function automatic logic [CLUSTER_BITS-1:0] random_cluster();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      return r[CLUSTER_BITS-1:0];
   endfunction

   function automatic bx_info_t make_info(input logic bc0, input logic resync,
                                          input logic overflow, input logic [1:0] lsbs);
      bx_info_t info;
      info.bc0      = bc0;
      info.resync   = resync;
      info.bxn_lsbs = lsbs;
      info.overflow = overflow;
      return info;
   endfunction

   // One strobe, then four words per link and the idle word
   task automatic send_crossing(input logic [CLUSTER_BITS-1:0] cluster,
                                input bx_info_t info, input logic [7:0] exp_sep);
      link_payload_t half;
      cluster_data_i = cluster;
      bx_info_i      = info;
      bx_strobe_i    = 1'b1;
      next_cycle();
      bx_strobe_i    = 1'b0;
      cluster_data_i = ~cluster;          // Only the strobe cycle may be sampled
      bx_info_i      = '0;
      for (int w = 0; w <= FRAMES_PER_BX; w++) begin
         for (int i = 0; i < NUM_LINKS; i++) begin
            half = (i % 2 == 0) ? cluster[55:0] : cluster[111:56];  // Even low, odd high
            case (w)
               0:       check_word(i, {half[7:0], exp_sep}, 2'b01);
               1:       check_word(i, half[23:8], 2'b00);
               2:       check_word(i, half[39:24], 2'b00);
               3:       check_word(i, half[55:40], 2'b00);
               default: check_word(i, 16'hFFFC, 2'b01);
            endcase
         end
         next_cycle();
      end
   endtask

   //--------------------------------------------------------------------------
   // Directed tests
   //--------------------------------------------------------------------------

   task automatic apply_reset();
      rst_n_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_40);
      #1;
      check_value("mgt_reset_o", 64'(mgt_reset_o), 64'(4'hF));
      check_value("tx_reset_o", 64'(tx_reset_o), 64'(1'b0));
      check_value("ready_o", 64'(ready_o), 64'(1'b0));
      check_all_idle();
      rst_n_i = 1'b1;
      cyc     = 0;                        // Counter reads zero this cycle
   endtask

   // Staged release, one-cycle tx reset, strobes ignored until done
   task automatic startup_staging();
      logic [NUM_LINKS-1:0] exp_mgt;
      while (cyc <= DONE_CYC) begin
         for (int i = 0; i < NUM_LINKS; i++) begin
            exp_mgt[i] = (cyc < RELEASE_UNIT[i] * STARTUP_UNIT);
         end
         check_value("mgt_reset_o", 64'(mgt_reset_o), 64'(exp_mgt));
         check_value("tx_reset_o", 64'(tx_reset_o), 64'(cyc == TXRESET_CYC));
         check_all_idle();
         bx_strobe_i    = (cyc % 5 == 0) && (cyc < DONE_CYC - 8);
         cluster_data_i = random_cluster();
         next_cycle();
      end
      bx_strobe_i = 1'b0;
   endtask

   task automatic ready_timing();
      int restart_cyc;
      check_value("ready_o", 64'(ready_o), 64'(1'b0));
      wait_for_ready("after startup");
      check_value("ready_o rise cycle", 64'(cyc), 64'(DONE_CYC + READY_HOLD));
      tx_ready_i[2] = 1'b0;               // One transceiver drops out
      next_cycle();
      check_value("ready_o", 64'(ready_o), 64'(1'b0));
      tx_ready_i  = '1;
      restart_cyc = cyc;
      wait_for_ready("after tx_ready_i returned");
      check_value("ready_o hold after tx_ready_i", 64'(cyc - restart_cyc), 64'(READY_HOLD));
      force_not_ready_i = 1'b1;
      next_cycle();
      check_value("ready_o", 64'(ready_o), 64'(1'b0));
      force_not_ready_i = 1'b0;
      restart_cyc       = cyc;
      wait_for_ready("after force_not_ready_i cleared");
      check_value("ready_o hold after force", 64'(cyc - restart_cyc), 64'(READY_HOLD));
   endtask

   task automatic framing_random();
      logic [1:0] lsbs;
      for (int n = 0; n < 3; n++) begin
         lsbs = 2'($urandom);
         send_crossing(random_cluster(), make_info(1'b0, 1'b0, 1'b0, lsbs), SEQ_CODE[lsbs]);
      end
   endtask

   // bc0 over resync over overflow
   task automatic separator_priority();
      send_crossing(random_cluster(), make_info(1'b1, 1'b0, 1'b0, 2'd1), 8'hBC);
      send_crossing(random_cluster(), make_info(1'b1, 1'b1, 1'b1, 2'd2), 8'hBC);
      send_crossing(random_cluster(), make_info(1'b1, 1'b0, 1'b1, 2'd3), 8'hBC);
      send_crossing(random_cluster(), make_info(1'b0, 1'b1, 1'b0, 2'd0), 8'h3C);
      send_crossing(random_cluster(), make_info(1'b0, 1'b1, 1'b1, 2'd1), 8'h3C);
      send_crossing(random_cluster(), make_info(1'b0, 1'b0, 1'b1, 2'd2), 8'hFE);
   endtask

   task automatic sequence_codes();
      for (int s = 0; s < 4; s++) begin
         send_crossing(random_cluster(), make_info(1'b0, 1'b0, 1'b0, 2'(s)), SEQ_CODE[s]);
      end
   endtask

   task automatic inactive_output();
      force_not_ready_i = 1'b1;
      cluster_data_i    = random_cluster();
      bx_info_i         = make_info(1'b1, 1'b0, 1'b0, 2'd0);
      bx_strobe_i       = 1'b1;
      next_cycle();
      bx_strobe_i = 1'b0;
      for (int k = 0; k < 2; k++) begin
         check_all_idle();
         next_cycle();
      end
      force_not_ready_i = 1'b0;           // Link back while that frame would still run
      for (int k = 0; k < FRAMES_PER_BX; k++) begin
         check_all_idle();                // No stale frame once active again
         next_cycle();
      end
   endtask

   task automatic manual_overrides();
      mgt_reset_i = 4'b0101;
      txreset_i   = 1'b1;
      next_cycle();
      check_value("mgt_reset_o", 64'(mgt_reset_o), 64'(4'b0101));
      check_value("tx_reset_o", 64'(tx_reset_o), 64'(1'b1));
      mgt_reset_i = 4'b1010;
      txreset_i   = 1'b0;
      next_cycle();
      check_value("mgt_reset_o", 64'(mgt_reset_o), 64'(4'b1010));
      check_value("tx_reset_o", 64'(tx_reset_o), 64'(1'b0));
      mgt_reset_i = '0;
      next_cycle();
      check_value("mgt_reset_o", 64'(mgt_reset_o), 64'(4'b0000));
   endtask

   //--------------------------------------------------------------------------
   // Main sequence
   //--------------------------------------------------------------------------

   initial begin
      void'($urandom(SEED));
      rst_n_i           = 1'b0;
      bx_strobe_i       = 1'b0;
      cluster_data_i    = '0;
      bx_info_i         = '0;
      tx_ready_i        = '1;             // Transceivers report reset done
      force_not_ready_i = 1'b0;
      mgt_reset_i       = '0;
      txreset_i         = 1'b0;
      cyc               = 0;
      checks            = 0;
      errors            = 0;
      timeouts          = 0;
      apply_reset();
      startup_staging();
      ready_timing();
      framing_random();
      separator_priority();
      sequence_codes();
      inactive_output();
      manual_overrides();
      $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
source/gem_link_pkg.sv
source/startup_sequencer.sv
source/link_ready_timer.sv
source/frame_sep_select.sv
source/link_framer.sv
source/gem_data_out.sv
tb/tb_gem_data_out.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the GEM link framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f filelist.f --top-module tb_gem_data_out \
   -Mdir "$OBJ" -o tb_gem_data_out
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/tb_gem_data_out" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

# The log decides the outcome
if grep -q "Result: FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
   echo "No result line found in $LOG"
   exit 1
fi
exit 0
